//--- Bender.yml
package:
  name: sprite_line

sources:
  # packages first, then the design from the leaves up
  - files:
      - logic/vdp_pkg.sv
      - logic/sprite_pkg.sv
      - logic/sprite_attr_regs.sv
      - logic/sprite.sv
      - logic/sprite_mixer.sv
      - logic/sprite_line.sv

  # simulation only
  - target: test
    files:
      - tb/sprite_line_checker.sv
      - tb/sprite_line_tb.sv

//--- logic/sprite.sv
// single sprite unit
// latches its attributes at the load tick, then after the column-last tick
// waits out its horizontal position and shifts its pattern row out at VDP
// pixel rate (half that when magnified)
// one VDP pixel lasts two pxclk cycles

`timescale 1ns/10ps
`default_nettype none

module sprite (
    input  wire                              pxclk,         // 2x VDP pixel clock
    input  wire                              reset,         // synchronous, active high

    input  wire                              col_last_tick, // next cycle is position zero
    input  wire                              load_tick,     // time to latch the attributes
    input  wire                              mag,           // magnify setting to latch
    input  wire  sprite_pkg::sprite_attr_t   attr,          // attributes to latch

    output logic                             pixel_on,      // a set pattern bit is showing
    output vdp_pkg::color_t                  color          // colour while showing, else zero
);

    import vdp_pkg::*;

    //************************************************************************
    // latched line state
    //************************************************************************

    logic       active_reg;             // counting and rendering after col_last_tick
    logic [1:0] phase_reg;              // pxclk phase within a magnified VDP pixel
    logic       mag_reg;                // shift once per two VDP pixels when set
    hpos_t      hpos_reg;               // VDP pixels left before the pattern starts
    pattern_t   pattern_reg;            // row being shifted out, MSB is on screen
    color_t     color_reg;              // foreground colour for this line

    logic       vdp_step;               // last pxclk cycle of a VDP pixel while active
    logic       shift_en;               // move the next pattern bit onto the screen

    // the odd phases close a VDP pixel, phase 3 closes a magnified one
    assign vdp_step = active_reg && phase_reg[0];
    assign shift_en = vdp_step && (hpos_reg == '0) && (!mag_reg || phase_reg[1]);

    //************************************************************************
    // control
    //************************************************************************

    always_ff @(posedge pxclk) begin
        if (reset) begin
            active_reg <= 1'b0;
            phase_reg  <= 2'd0;
        end else begin
            // col_last_tick wins the active bit over a load in the same cycle
            if (col_last_tick) begin
                active_reg <= 1'b1;
            end else if (load_tick) begin
                active_reg <= 1'b0;         // idle until the next line starts
            end
            // resync the phase so the first active cycle is phase 0
            phase_reg <= col_last_tick ? 2'd0 : phase_reg + 2'd1;
        end
    end

    //************************************************************************
    // position counter and pattern shifter
    //************************************************************************

    always_ff @(posedge pxclk) begin
        if (reset) begin
            mag_reg     <= 1'b0;
            hpos_reg    <= '0;
            pattern_reg <= '0;
            color_reg   <= '0;
        end else if (load_tick) begin
            mag_reg     <= mag;
            // without the early bit the sprite starts 32 VDP pixels further right
            hpos_reg    <= attr.early ? attr.xpos : attr.xpos + EARLY_SHIFT;
            pattern_reg <= attr.pattern;
            color_reg   <= attr.color;
        end else begin
            if (vdp_step && hpos_reg != '0) begin
                hpos_reg <= hpos_reg - 1'b1;    // one VDP pixel closer to the start
            end
            if (shift_en) begin
                pattern_reg <= {pattern_reg[14:0], 1'b0};   // zeros fill in behind
            end
        end
    end

    // the sprite shows once the position has run out and the MSB is set
    assign pixel_on = active_reg && (hpos_reg == '0) && pattern_reg[15];
    assign color    = pixel_on ? color_reg : '0;

endmodule

`default_nettype wire

//--- logic/sprite_attr_regs.sv
// sprite attribute registers
// host-written attribute entry per sprite plus the global magnify bit
// the sprite units pick these up at their load tick, so a write here
// only takes effect on the line after the next load

`timescale 1ns/10ps
`default_nettype none

module sprite_attr_regs (
    input  wire                              pxclk,     // 2x VDP pixel clock
    input  wire                              reset,     // synchronous, active high

    // host write port, single-cycle strobes with no acknowledge
    input  wire                              wr_en,     // write wr_attr into entry wr_idx
    input  wire  sprite_pkg::sprite_idx_t    wr_idx,    // entry to write
    input  wire  sprite_pkg::sprite_attr_t   wr_attr,   // new attributes for that entry
    input  wire                              ctrl_wr,   // write mag_in into the magnify bit
    input  wire                              mag_in,    // new magnify setting

    // register outputs toward the sprite units
    output sprite_pkg::sprite_attr_array_t   attrs,     // one entry per sprite unit
    output logic                             mag        // global 2x pixel size
);

    import sprite_pkg::*;

    //************************************************************************
    // write decode
    //************************************************************************

    // one-hot select of the entry being written this cycle
    logic [NUM_SPRITES-1:0] entry_sel;

    always_comb begin
        for (int i = 0; i < NUM_SPRITES; i++) begin
            entry_sel[i] = wr_en && (wr_idx == sprite_idx_t'(i));
        end
    end

    //************************************************************************
    // attribute storage
    //************************************************************************

    // cleared entries have an empty pattern and a transparent colour,
    // so an unwritten sprite never shows
    always_ff @(posedge pxclk) begin
        if (reset) begin
            attrs <= '0;
        end else begin
            for (int i = 0; i < NUM_SPRITES; i++) begin
                if (entry_sel[i]) begin
                    attrs[i] <= wr_attr;            // whole entry replaced at once
                end
            end
        end
    end

    // magnify is global, every sprite doubles its VDP pixels together
    always_ff @(posedge pxclk) begin
        if (reset) begin
            mag <= 1'b0;
        end else if (ctrl_wr) begin
            mag <= mag_in;
        end
    end

endmodule

`default_nettype wire

//--- logic/sprite_line.sv
// sprite line engine, top level
// attribute registers feed four sprite units whose outputs meet in the
// priority mixer
// px_color trails the units by one cycle, so the first possible pixel
// comes 2H+2 cycles after col_last_tick

`timescale 1ns/10ps
`default_nettype none

module sprite_line (
    input  wire                              pxclk,         // 2x VDP pixel clock
    input  wire                              reset,         // synchronous, active high

    // host side
    input  wire                              wr_en,         // attribute write strobe
    input  wire  sprite_pkg::sprite_idx_t    wr_idx,        // sprite being written
    input  wire  sprite_pkg::sprite_attr_t   wr_attr,       // its new attributes
    input  wire                              ctrl_wr,       // magnify write strobe
    input  wire                              mag_in,        // new magnify setting

    // video timing
    input  wire                              load_tick,     // units latch their attributes
    input  wire                              col_last_tick, // units start counting
    input  wire                              status_rd,     // clears the coincidence flag

    output vdp_pkg::color_t                  px_color,      // sprite colour, zero when none
    output logic                             coinc          // sticky coincidence flag
);

    import vdp_pkg::*;
    import sprite_pkg::*;

    sprite_attr_array_t         attrs;      // register block outputs, split per unit
    logic                       mag;        // global magnify bit
    logic [NUM_SPRITES-1:0]     pixel_on;   // unit pattern bits on screen
    color_t [NUM_SPRITES-1:0]   colors;     // unit colours, already gated by pixel_on

    sprite_attr_regs u_regs (
        .pxclk      (pxclk),
        .reset      (reset),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_attr    (wr_attr),
        .ctrl_wr    (ctrl_wr),
        .mag_in     (mag_in),
        .attrs      (attrs),
        .mag        (mag)
    );

    // unit i renders entry i, its index is also its priority
    for (genvar i = 0; i < NUM_SPRITES; i++) begin : g_sprite
        sprite u_sprite (
            .pxclk          (pxclk),
            .reset          (reset),
            .col_last_tick  (col_last_tick),
            .load_tick      (load_tick),
            .mag            (mag),
            .attr           (attrs[i]),
            .pixel_on       (pixel_on[i]),
            .color          (colors[i])
        );
    end

    sprite_mixer u_mixer (
        .pxclk      (pxclk),
        .reset      (reset),
        .pixel_on   (pixel_on),
        .colors     (colors),
        .status_rd  (status_rd),
        .px_color   (px_color),
        .coinc      (coinc)
    );

endmodule

`default_nettype wire

//--- logic/sprite_mixer.sv
// sprite priority mixer
// passes the colour of the lowest-numbered opaque sprite on the pixel and
// keeps a sticky coincidence flag for overlapping set pattern bits
// both outputs are registered, one cycle behind the sprite units

`timescale 1ns/10ps
`default_nettype none

module sprite_mixer (
    input  wire                                          pxclk,     // 2x VDP pixel clock
    input  wire                                          reset,     // synchronous, active high

    input  wire  [sprite_pkg::NUM_SPRITES-1:0]           pixel_on,  // per unit, set bit showing
    input  wire  vdp_pkg::color_t [sprite_pkg::NUM_SPRITES-1:0] colors, // gated unit colours
    input  wire                                          status_rd, // status read clears coinc

    output vdp_pkg::color_t                              px_color,  // winning colour or zero
    output logic                                         coinc      // sticky overlap flag
);

    import vdp_pkg::*;
    import sprite_pkg::*;

    logic [NUM_SPRITES-1:0] opaque;     // showing with a nonzero colour
    color_t                 color_next; // colour that wins this cycle
    logic                   multi;      // two or more pattern bits overlap

    // scan from the lowest priority up so sprite 0 is assigned last and wins
    // a transparent sprite never wins, so the one below it shows through
    always_comb begin
        color_next = '0;
        for (int i = NUM_SPRITES - 1; i >= 0; i--) begin
            opaque[i] = pixel_on[i] && (colors[i] != '0);
            if (opaque[i]) begin
                color_next = colors[i];
            end
        end
    end

    // clearing the lowest set bit leaves something only if a second bit was set
    assign multi = |(pixel_on & (pixel_on - 1'b1));

    always_ff @(posedge pxclk) begin
        if (reset) begin
            px_color <= '0;
            coinc    <= 1'b0;
        end else begin
            px_color <= color_next;
            // a new overlap beats a status read in the same cycle
            if (multi) begin
                coinc <= 1'b1;
            end else if (status_rd) begin
                coinc <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/sprite_pkg.sv
// sprite definitions
// sprite count, the index type used to address one sprite and the
// attribute record that the host loads for each sprite

`default_nettype none

package sprite_pkg;

    // number of sprites overlaid on one scan line
    localparam int unsigned NUM_SPRITES = 4;

    // selects one of the sprites, also its priority (0 is the highest)
    typedef logic [1:0] sprite_idx_t;

    // attributes of one sprite for the current row, 30 bits in total
    typedef struct packed {
        vdp_pkg::hpos_t    xpos;            // position as written by the host
        logic              early;           // set to pull the sprite 32 VDP pixels left
        vdp_pkg::color_t   color;           // foreground colour, zero hides the sprite
        vdp_pkg::pattern_t pattern;         // row pattern, MSB is the leftmost pixel
    } sprite_attr_t;

    // all sprite entries side by side
    // element i belongs to sprite unit i
    typedef sprite_attr_t [NUM_SPRITES-1:0] sprite_attr_array_t;

endpackage

`default_nettype wire

//--- logic/vdp_pkg.sv
// VDP pixel-level types
// shared by everything on the video path that handles colours, horizontal
// positions or pattern rows in VDP pixel units

`default_nettype none

package vdp_pkg;

    // palette index into the 16-entry VDP palette
    typedef logic [3:0] color_t;            // zero is transparent, lower layers show through

    // horizontal position counted in VDP pixels
    // zero sits 32 VDP pixels left of the active region so a sprite can slide in from the left
    typedef logic [8:0] hpos_t;

    // one pattern row, shifted out MSB first
    typedef logic [15:0] pattern_t;         // an 8-pixel sprite leaves the low byte zero

    // offset added to the position when the early clock bit is clear
    // with early set the sprite moves 32 VDP pixels to the left
    localparam hpos_t EARLY_SHIFT = 9'd32;

endpackage

`default_nettype wire

//--- sprite_line.f
logic/vdp_pkg.sv
logic/sprite_pkg.sv
logic/sprite_attr_regs.sv
logic/sprite.sv
logic/sprite_mixer.sv
logic/sprite_line.sv
tb/sprite_line_checker.sv
tb/sprite_line_tb.sv

//--- tb/sprite_line_checker.sv
// sprite line assertions
// bound into the top level, watches the reset state, the mixer output
// against the unit outputs and the way the coincidence flag clears

`timescale 1ns/10ps
`default_nettype none

module sprite_line_checker (
    input wire                                   pxclk,
    input wire                                   reset,
    input wire [sprite_pkg::NUM_SPRITES-1:0]     pixel_on,   // unit outputs inside the top
    input wire vdp_pkg::color_t                  px_color,
    input wire                                   coinc,
    input wire                                   status_rd
);

    //************************************************************************
    // reset state
    //************************************************************************

    // a reset cycle leaves both mixer outputs cleared
    a_reset_clear : assert property (@(posedge pxclk)
        reset |=> (px_color == '0 && coinc == 1'b0))
        else $error("px_color or coinc not clear after reset");

    //************************************************************************
    // mixer output
    //************************************************************************

    // a colour needs some unit showing a pattern bit one cycle before
    a_color_source : assert property (@(posedge pxclk) disable iff (reset)
        (px_color != '0) |-> $past(|pixel_on))
        else $error("px_color set without any unit pixel one cycle earlier");

    // the sticky flag only drops after a status read
    a_coinc_sticky : assert property (@(posedge pxclk) disable iff (reset)
        $fell(coinc) |-> ($past(status_rd) || $past(reset)))
        else $error("coinc fell without a status read");

endmodule

bind sprite_line sprite_line_checker u_checker (
    .pxclk      (pxclk),
    .reset      (reset),
    .pixel_on   (pixel_on),
    .px_color   (px_color),
    .coinc      (coinc),
    .status_rd  (status_rd)
);

`default_nettype wire

//--- tb/sprite_line_tb.sv
// sprite line engine testbench
// applies a table of scan-line scenarios and compares every pixel of the
// line with a reference model of the sprite and mixer rules

`timescale 1ns/10ps
`default_nettype none

module sprite_line_tb;

    import vdp_pkg::*;
    import sprite_pkg::*;

    // one scan-line scenario of the table
    typedef struct packed {
        sprite_attr_array_t attrs;          // attributes written before the load tick
        logic               mag;            // magnify bit for the line
        int                 len;            // cycles checked after col_last_tick
        int                 rd_at;          // line cycle of the status read, negative for none
        logic               coinc;          // coincidence expected at the end of the line
        logic               late;           // write sprite 0 again after the load tick
        sprite_attr_t       late_attr;      // attributes of that late write
    } row_t;

    logic               pxclk;
    logic               reset;
    logic               wr_en;
    sprite_idx_t        wr_idx;
    sprite_attr_t       wr_attr;
    logic               ctrl_wr;
    logic               mag_in;
    logic               load_tick;
    logic               col_last_tick;
    logic               status_rd;
    color_t             px_color;
    logic               coinc;

    row_t               rows[$];            // directed rows first, then random ones
    int                 n_directed;
    int                 seed = 32'h5bb3_1f69;
    int                 color_errors = 0;
    int                 flag_errors = 0;
    int                 timeout_errors = 0;

    sprite_line DUT (.*);

    initial begin
        pxclk = 1'b0;
        forever #2 pxclk = ~pxclk;          // 4 ns period
    end

    //************************************************************************
    // helpers
    //************************************************************************

    // inputs change 1 ns after the edge, outputs are read at the same point
    task automatic tick();
        @(posedge pxclk);
        #1;
    endtask

    task automatic check_color(string name, color_t got, color_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            color_errors++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            flag_errors++;
        end
    endtask

    function automatic sprite_attr_t attr_of(int x, logic e, color_t c, pattern_t p);
        sprite_attr_t a;
        a.xpos    = hpos_t'(x);
        a.early   = e;
        a.color   = c;
        a.pattern = p;
        return a;
    endfunction

    function automatic row_t scenario(sprite_attr_t s0, sprite_attr_t s1, sprite_attr_t s2,
                                      sprite_attr_t s3, logic m, int len, int rd_at,
                                      logic co, logic late = 1'b0,
                                      sprite_attr_t late_attr = '0);
        row_t r;
        r.attrs     = {s3, s2, s1, s0};     // element i is sprite i
        r.mag       = m;
        r.len       = len;
        r.rd_at     = rd_at;
        r.coinc     = co;
        r.late      = late;
        r.late_attr = late_attr;
        return r;
    endfunction

    // pattern bit showing d cycles after the first active cycle, 0 when none
    function automatic logic unit_on(sprite_attr_t a, logic m, int d);
        int h2;
        int idx;
        h2  = 2 * (int'(a.xpos) + (a.early ? 0 : 32));  // start cycle is twice H
        idx = 0;
        if (d < h2) return 1'b0;
        if (!m) begin
            idx = (d - h2) / 2;             // one bit per VDP pixel
        end else begin
            for (int c = h2; c < d; c++) begin
                if (c % 4 == 3) idx++;      // one bit per two VDP pixels
            end
        end
        if (idx > 15) return 1'b0;
        return a.pattern[15 - idx];
    endfunction

    task automatic write_regs(row_t r);
        for (int i = 0; i < NUM_SPRITES; i++) begin
            wr_en   = 1'b1;
            wr_idx  = sprite_idx_t'(i);
            wr_attr = r.attrs[i];
            tick();
        end
        wr_en   = 1'b0;
        ctrl_wr = 1'b1;
        mag_in  = r.mag;
        tick();
        ctrl_wr = 1'b0;
    endtask

    // load, start and check one line
    // the expected values trail the unit model by the mixer register
    task automatic run_line(sprite_attr_array_t a, logic m, int len, int rd_at,
                            logic late, sprite_attr_t late_attr);
        logic [NUM_SPRITES-1:0] on;
        color_t                 exp_color;
        logic                   exp_coinc;
        load_tick = 1'b1;
        tick();
        load_tick     = 1'b0;
        col_last_tick = 1'b1;
        if (late) begin                     // lands in the registers only, units are loaded
            wr_en   = 1'b1;
            wr_idx  = '0;
            wr_attr = late_attr;
        end
        tick();
        col_last_tick = 1'b0;
        wr_en         = 1'b0;
        exp_color     = '0;
        exp_coinc     = 1'b0;               // cleared by the previous line's status read
        for (int j = 0; j < len; j++) begin
            check_color("px_color", px_color, exp_color);
            check_flag("coinc", coinc, exp_coinc);
            status_rd = (j == rd_at);
            for (int i = 0; i < NUM_SPRITES; i++) on[i] = unit_on(a[i], m, j);
            exp_color = '0;
            for (int i = 0; i < NUM_SPRITES; i++) begin
                if (on[i] && a[i].color != '0 && exp_color == '0) exp_color = a[i].color;
            end
            exp_coinc = ($countones(on) > 1) || (exp_coinc && !status_rd);  // a set wins
            tick();
        end
        status_rd = 1'b0;
        check_color("px_color", px_color, exp_color);   // last cycle of the line
        check_flag("coinc", coinc, exp_coinc);
    endtask

    //************************************************************************
    // main sequence
    //************************************************************************

    initial begin
        int    n;
        row_t  r;
        sprite_attr_array_t a;
        reset = 1'b1;
        {wr_en, wr_idx, wr_attr, ctrl_wr, mag_in} = '0;
        {load_tick, col_last_tick, status_rd}     = '0;

        // positions and early clock, then pattern shifting
        rows.push_back(scenario(attr_of(0, 1, 4'h5, 16'h8000), '0, '0, '0, 0, 200, -1, 0));
        rows.push_back(scenario(attr_of(0, 0, 4'h5, 16'hf000), '0, '0, '0, 0, 200, -1, 0));
        rows.push_back(scenario('0, attr_of(7, 1, 4'h9, 16'ha500), '0, '0, 0, 200, -1, 0));
        rows.push_back(scenario('0, '0, attr_of(20, 0, 4'h3, 16'hffff), '0, 0, 200, -1, 0));
        rows.push_back(scenario('0, '0, '0, attr_of(5, 1, 4'h6, 16'hc3a5), 1, 200, -1, 0));
        rows.push_back(scenario(attr_of(4, 1, 4'hc, 16'h8100), '0, '0, '0, 1, 200, -1, 0));
        rows.push_back(scenario(attr_of(9, 0, 4'hd, 16'h5a00), '0, '0, '0, 0, 200, -1, 0));
        // priority and a transparent sprite in front
        rows.push_back(scenario(attr_of(4, 1, 4'h2, 16'hff00), attr_of(6, 1, 4'h7, 16'hffff),
                                '0, '0, 0, 200, -1, 1));
        rows.push_back(scenario(attr_of(4, 1, 4'h0, 16'hffff), attr_of(4, 1, 4'ha, 16'hf0f0),
                                '0, '0, 0, 200, -1, 1));
        // coincidence: disjoint, cleared by a read, and a set beating a read
        rows.push_back(scenario(attr_of(0, 1, 4'hb, 16'hf000), '0,
                                attr_of(40, 1, 4'he, 16'hf000), '0, 0, 200, -1, 0));
        rows.push_back(scenario(attr_of(0, 1, 4'h1, 16'h8000), attr_of(0, 1, 4'h2, 16'h8000),
                                '0, '0, 0, 200, 50, 0));
        rows.push_back(scenario(attr_of(10, 1, 4'h4, 16'hffff), '0, '0,
                                attr_of(10, 1, 4'h6, 16'h8000), 0, 200, 20, 1));
        // write after the load tick, shows only on the following line
        rows.push_back(scenario(attr_of(3, 1, 4'h1, 16'hff00), '0, '0, '0, 0, 200, -1, 0,
                                1, attr_of(12, 1, 4'he, 16'hf0f0)));
        n_directed = rows.size();
        for (int k = 0; k < 6; k++) begin
            for (int i = 0; i < NUM_SPRITES; i++) begin
                a[i] = attr_of($random(seed) & 63, $random(seed), $random(seed), $random(seed));
            end
            rows.push_back(scenario(a[0], a[1], a[2], a[3], $random(seed), 300,
                                    $random(seed) & 255, 0));
        end

        repeat (8) @(posedge pxclk);
        #1;
        reset = 1'b0;
        n = 0;
        while ((px_color !== '0 || coinc !== 1'b0) && n < 16) begin  // bounded wait
            tick();
            n++;
        end
        if (px_color !== '0 || coinc !== 1'b0) begin
            $display("timeout: px_color and coinc never read zero after reset");
            timeout_errors++;
        end
        run_line('0, 1'b0, 120, -1, 1'b0, '0);      // untouched registers keep it blank

        foreach (rows[k]) begin
            r = rows[k];
            write_regs(r);
            run_line(r.attrs, r.mag, r.len, r.rd_at, r.late, r.late_attr);
            if (k < n_directed) check_flag("coinc at line end", coinc, r.coinc);
            if (r.late) begin
                a    = r.attrs;
                a[0] = r.late_attr;
                status_rd = 1'b1;
                tick();
                status_rd = 1'b0;
                run_line(a, r.mag, r.len, -1, 1'b0, '0);
            end
            status_rd = 1'b1;               // clear the flag for the next row
            tick();
            status_rd = 1'b0;
            check_flag("coinc after status read", coinc, 1'b0);
        end

        $display("errors: %0d colour, %0d flag, %0d timeout",
                 color_errors, flag_errors, timeout_errors);
        if (color_errors + flag_errors + timeout_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // the whole run fits well inside this limit
    initial begin
        #1_000_000;
        $display("simulation did not reach the end of the scenario table in time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
